// File: rtl/axi_pkg.sv
`default_nettype none

package axi_pkg;

    localparam int DATA_W  = 32;            // write data bus
    localparam int ID_W    = 2;             // transaction id
    localparam int LEN_W   = 8;             // beats minus one
    localparam int ADDR_W  = 32;
    localparam int BURST_W = 2;
    localparam int STRB_W  = DATA_W / 8;    // one strobe per byte

    localparam logic [STRB_W-1:0] STRB_ALL = '1;    // every byte lane valid

    localparam logic [BURST_W-1:0] BURST_FIXED = 2'b00;
    localparam logic [BURST_W-1:0] BURST_INCR  = 2'b01;
    localparam logic [BURST_W-1:0] BURST_WRAP  = 2'b10;

    // aw and ar carry the same fields, 44 bits
    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [ADDR_W-1:0]  addr;
        logic [LEN_W-1:0]   len;
        logic [BURST_W-1:0] burst;
    } axi_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;    // final beat of the data frame
    } axi_w_t;

endpackage

`default_nettype wire

// File: rtl/udp_cmd_pkg.sv
`default_nettype none

package udp_cmd_pkg;

    localparam int WORD_W = 32;     // one udp_rx_data word
    localparam int TAG_W  = 8;      // top byte of a word

    localparam logic [TAG_W-1:0] TAG_CMD  = 8'h00;  // command frame / valid header
    localparam logic [TAG_W-1:0] TAG_DATA = 8'hff;  // data frame marker

    localparam int DESC_DEPTH = 16;     // per address FIFO
    localparam int BEAT_DEPTH = 64;     // write data FIFO

    // high word arrives first, so tag sits in bits 63:56
    typedef struct packed {
        logic [TAG_W-1:0]            tag;       // 63:56
        logic [axi_pkg::BURST_W-1:0] burst;     // 55:54
        logic [axi_pkg::ID_W-1:0]    id;        // 53:52
        logic [2:0]                  rsvd_hi;   // 51:49
        logic                        wr;        // 48, 1 = aw, 0 = ar
        logic [axi_pkg::LEN_W-1:0]   len;       // 47:40
        logic [7:0]                  rsvd_lo;   // 39:32
        logic [axi_pkg::ADDR_W-1:0]  addr;      // 31:0
    } cmd_header_t;

endpackage

`default_nettype wire

// File: rtl/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16           // power of two
) (
    input  wire           gmii_rx_clk,
    input  wire           rstn,
    input  wire           push,
    input  wire payload_t push_data,
    input  wire           pop,
    output payload_t      head,             // show-ahead, valid when !empty
    output logic          empty,
    output logic          full
);

    localparam int AW = $clog2(DEPTH);

    payload_t       mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count;                  // one extra bit to tell full from empty
    logic           do_push;
    logic           do_pop;

    assign do_push = push && !full;         // overflow drops the entry
    assign do_pop  = pop && !empty;
    assign empty   = count == '0;
    assign full    = count == (AW+1)'(DEPTH);
    assign head    = mem[rd_ptr];

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // wraps at DEPTH
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // both or neither
            endcase
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

endmodule

`default_nettype wire

// File: rtl/udp_frame_parser.sv
`timescale 1ns/1ns
`default_nettype none

module udp_frame_parser (
    input  wire                              gmii_rx_clk,
    input  wire                              rstn,
    input  wire                              udp_rx_en,
    input  wire                              udp_rx_done,
    input  wire [udp_cmd_pkg::WORD_W-1:0]    udp_rx_data,
    output logic                             aw_push,
    output axi_pkg::axi_aw_t                 aw_desc,
    output logic                             ar_push,
    output axi_pkg::axi_aw_t                 ar_desc,
    output logic                             w_push,
    output axi_pkg::axi_w_t                  w_beat
);

    typedef enum logic [1:0] {
        st_idle,        // waiting for the first word of a frame
        st_cmd,         // header pairs
        st_data,        // write beats
        st_skip         // unknown tag, wait for done
    } state_t;

    state_t                             state;
    logic                               odd;        // high word held, low word next
    logic [udp_cmd_pkg::WORD_W-1:0]     hi_word;
    logic [udp_cmd_pkg::TAG_W-1:0]      word_tag;
    udp_cmd_pkg::cmd_header_t           hdr;
    axi_pkg::axi_aw_t                   desc_q;     // shared by both address FIFOs
    logic                               pair_done;

    assign word_tag  = udp_rx_data[udp_cmd_pkg::WORD_W-1 -: udp_cmd_pkg::TAG_W];
    assign hdr       = {hi_word, udp_rx_data};      // only meaningful on the low word
    assign pair_done = udp_rx_en && state == st_cmd && odd;
    assign aw_desc   = desc_q;
    assign ar_desc   = desc_q;                      // push strobe picks the FIFO

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            state   <= st_idle;
            odd     <= 1'b0;
            aw_push <= 1'b0;
            ar_push <= 1'b0;
            w_push  <= 1'b0;
        end else begin
            aw_push <= 1'b0;        // single-cycle strobes
            ar_push <= 1'b0;
            w_push  <= 1'b0;
            if (udp_rx_en) begin
                case (state)
                    st_idle: begin
                        odd <= word_tag == udp_cmd_pkg::TAG_CMD;  // first word is a high word
                        if (word_tag == udp_cmd_pkg::TAG_CMD) state <= st_cmd;
                        else if (word_tag == udp_cmd_pkg::TAG_DATA) state <= st_data;
                        else state <= st_skip;
                    end
                    st_cmd: begin
                        odd <= !odd;
                        if (odd && hdr.tag == udp_cmd_pkg::TAG_CMD) begin
                            aw_push <= hdr.wr;      // bit 48 picks the channel
                            ar_push <= !hdr.wr;
                        end
                    end
                    st_data: w_push <= 1'b1;        // marker already dropped in idle
                    default: ;                      // skip ignores the word
                endcase
                if (udp_rx_done) state <= st_idle;  // odd last word falls away here
            end
        end
    end

    // payload side, no reset
    always_ff @(posedge gmii_rx_clk) begin
        if (udp_rx_en && !(state == st_cmd && odd)) hi_word <= udp_rx_data;
        if (pair_done) begin
            desc_q <= '{id: hdr.id, addr: hdr.addr, len: hdr.len, burst: hdr.burst};
        end
        if (udp_rx_en && state == st_data) begin
            w_beat <= '{data: udp_rx_data, strb: axi_pkg::STRB_ALL, last: udp_rx_done};
        end
    end

endmodule

`default_nettype wire

// File: rtl/axi_addr_issuer.sv
`timescale 1ns/1ns
`default_nettype none

module axi_addr_issuer (
    input  wire                   gmii_rx_clk,
    input  wire                   rstn,
    input  wire axi_pkg::axi_aw_t fifo_head,
    input  wire                   fifo_empty,
    input  wire                   ready,
    output logic                  fifo_pop,
    output axi_pkg::axi_aw_t      desc,
    output logic                  valid
);

    // take a new descriptor only while nothing is offered
    assign fifo_pop = !valid && !fifo_empty;

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            valid <= 1'b0;
        end else if (valid) begin
            if (ready) valid <= 1'b0;       // handshake done, go idle
        end else if (!fifo_empty) begin
            valid <= 1'b1;                  // same edge as the pop
        end
    end

    // held stable for the whole offer
    always_ff @(posedge gmii_rx_clk) begin
        if (fifo_pop) desc <= fifo_head;
    end

endmodule

`default_nettype wire

// File: rtl/axi_wdata_streamer.sv
`timescale 1ns/1ns
`default_nettype none

module axi_wdata_streamer (
    input  wire                  gmii_rx_clk,
    input  wire                  rstn,
    input  wire axi_pkg::axi_w_t fifo_head,
    input  wire                  fifo_empty,
    input  wire                  w_ready,
    input  wire                  b_valid,
    output logic                 fifo_pop,
    output axi_pkg::axi_w_t      w,
    output logic                 w_valid,
    output logic                 b_ready
);

    logic load;

    // stage empty, or its beat leaves this cycle
    assign load     = !fifo_empty && (!w_valid || w_ready);
    assign fifo_pop = load;

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            w_valid <= 1'b0;
            b_ready <= 1'b0;
        end else begin
            if (load) begin
                w_valid <= 1'b1;            // back-to-back, no bubble
            end else if (w_ready) begin
                w_valid <= 1'b0;            // handed off, nothing queued
            end
            // arm after reset, re-arm on each dropped response
            if (!b_ready || b_valid) b_ready <= 1'b1;
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (load) w <= fifo_head;
    end

endmodule

`default_nettype wire

// File: rtl/udp_axi_cmd.sv
`timescale 1ns/1ns
`default_nettype none

module udp_axi_cmd (
    input  wire                           gmii_rx_clk,
    input  wire                           rstn,
    input  wire                           udp_rx_en,
    input  wire                           udp_rx_done,
    input  wire [udp_cmd_pkg::WORD_W-1:0] udp_rx_data,
    input  wire                           aw_ready,
    input  wire                           ar_ready,
    input  wire                           w_ready,
    input  wire                           b_valid,
    output axi_pkg::axi_aw_t              aw,
    output logic                          aw_valid,
    output axi_pkg::axi_aw_t              ar,
    output logic                          ar_valid,
    output axi_pkg::axi_w_t               w,
    output logic                          w_valid,
    output logic                          b_ready
);

    logic             aw_push;      // parser side
    logic             ar_push;
    logic             w_push;
    axi_pkg::axi_aw_t aw_desc;
    axi_pkg::axi_aw_t ar_desc;
    axi_pkg::axi_w_t  w_beat;

    axi_pkg::axi_aw_t aw_head;      // FIFO heads
    axi_pkg::axi_aw_t ar_head;
    axi_pkg::axi_w_t  w_head;
    logic             aw_empty;
    logic             ar_empty;
    logic             w_empty;
    logic             aw_pop;
    logic             ar_pop;
    logic             w_pop;

    udp_frame_parser i_parser (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .udp_rx_en   (udp_rx_en),
        .udp_rx_done (udp_rx_done),
        .udp_rx_data (udp_rx_data),
        .aw_push     (aw_push),
        .aw_desc     (aw_desc),
        .ar_push     (ar_push),
        .ar_desc     (ar_desc),
        .w_push      (w_push),
        .w_beat      (w_beat)
    );

    sync_fifo #(
        .payload_t (axi_pkg::axi_aw_t),
        .DEPTH     (udp_cmd_pkg::DESC_DEPTH)
    ) i_aw_fifo (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .push        (aw_push),
        .push_data   (aw_desc),
        .pop         (aw_pop),
        .head        (aw_head),
        .empty       (aw_empty),
        .full        ()             // overflow handled inside, no back-pressure
    );

    sync_fifo #(
        .payload_t (axi_pkg::axi_aw_t),
        .DEPTH     (udp_cmd_pkg::DESC_DEPTH)
    ) i_ar_fifo (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .push        (ar_push),
        .push_data   (ar_desc),
        .pop         (ar_pop),
        .head        (ar_head),
        .empty       (ar_empty),
        .full        ()
    );

    sync_fifo #(
        .payload_t (axi_pkg::axi_w_t),
        .DEPTH     (udp_cmd_pkg::BEAT_DEPTH)
    ) i_w_fifo (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .push        (w_push),
        .push_data   (w_beat),
        .pop         (w_pop),
        .head        (w_head),
        .empty       (w_empty),
        .full        ()
    );

    axi_addr_issuer i_aw_issuer (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .fifo_head   (aw_head),
        .fifo_empty  (aw_empty),
        .ready       (aw_ready),
        .fifo_pop    (aw_pop),
        .desc        (aw),
        .valid       (aw_valid)
    );

    axi_addr_issuer i_ar_issuer (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .fifo_head   (ar_head),
        .fifo_empty  (ar_empty),
        .ready       (ar_ready),
        .fifo_pop    (ar_pop),
        .desc        (ar),
        .valid       (ar_valid)
    );

    axi_wdata_streamer i_w_streamer (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .fifo_head   (w_head),
        .fifo_empty  (w_empty),
        .w_ready     (w_ready),
        .b_valid     (b_valid),
        .fifo_pop    (w_pop),
        .w           (w),
        .w_valid     (w_valid),
        .b_ready     (b_ready)
    );

endmodule

`default_nettype wire

// File: dv/udp_axi_cmd_chk.sv
`timescale 1ns/1ns
`default_nettype none

module udp_axi_cmd_chk (
    input wire                   gmii_rx_clk,
    input wire                   rstn,
    input wire axi_pkg::axi_aw_t aw,
    input wire                   aw_valid,
    input wire                   aw_ready,
    input wire axi_pkg::axi_aw_t ar,
    input wire                   ar_valid,
    input wire                   ar_ready,
    input wire axi_pkg::axi_w_t  w,
    input wire                   w_valid,
    input wire                   w_ready,
    input wire                   b_ready
);

    int fail_count = 0;     // read by the testbench summary

    a_aw_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else begin fail_count++; $error("aw dropped or changed while stalled"); end

    a_ar_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else begin fail_count++; $error("ar dropped or changed while stalled"); end

    a_w_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else begin fail_count++; $error("w dropped or changed while stalled"); end

    // async reset, so valids must already be low here
    a_reset_quiet: assert property (@(posedge gmii_rx_clk)
        !rstn |-> !aw_valid && !ar_valid && !w_valid)
        else begin fail_count++; $error("valid high during reset"); end

    a_bready_up: assert property (@(posedge gmii_rx_clk) $rose(rstn) |=> b_ready)
        else begin fail_count++; $error("b_ready not high after reset release"); end

    a_bready_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        $past(b_ready) |-> b_ready)
        else begin fail_count++; $error("b_ready fell after going high"); end

endmodule

bind udp_axi_cmd udp_axi_cmd_chk i_chk (
    .gmii_rx_clk (gmii_rx_clk),
    .rstn        (rstn),
    .aw          (aw),
    .aw_valid    (aw_valid),
    .aw_ready    (aw_ready),
    .ar          (ar),
    .ar_valid    (ar_valid),
    .ar_ready    (ar_ready),
    .w           (w),
    .w_valid     (w_valid),
    .w_ready     (w_ready),
    .b_ready     (b_ready)
);

`default_nettype wire

// File: dv/udp_axi_cmd_checker.sv
`timescale 1ns/1ns
`default_nettype none

module udp_axi_cmd_checker (
    input wire                   gmii_rx_clk,
    input wire                   rstn,
    input wire axi_pkg::axi_aw_t aw,
    input wire                   aw_valid,
    input wire                   aw_ready,
    input wire axi_pkg::axi_aw_t ar,
    input wire                   ar_valid,
    input wire                   ar_ready,
    input wire axi_pkg::axi_w_t  w,
    input wire                   w_valid,
    input wire                   w_ready
);

    logic [63:0] exp_q [3][$];                  // 0 aw, 1 ar, 2 w, zero-extended
    string       ch_name [3] = '{"aw", "ar", "w"};
    int          errors      = 0;
    int          test_errors = 0;
    int          checked     = 0;

    task automatic add_expected(input int ch, input logic [63:0] value);
        exp_q[ch].push_back(value);
    endtask

    function automatic int pending();
        return exp_q[0].size() + exp_q[1].size() + exp_q[2].size();
    endfunction

    task automatic check_item(input int ch, input logic [63:0] got);
        logic [63:0] want;
        if (exp_q[ch].size() == 0) begin
            $display("unexpected handshake on %s, nothing was expected", ch_name[ch]);
            test_errors++;
        end else begin
            want = exp_q[ch].pop_front();
            checked++;
            if (got !== want) begin
                $display("Mismatch %s: expected %h, got %h", ch_name[ch], want, got);
                test_errors++;
            end
        end
    endtask

    // handshake values are the pre-edge ones
    always @(posedge gmii_rx_clk) begin
        if (rstn && aw_valid && aw_ready) check_item(0, 64'(aw));
        if (rstn && ar_valid && ar_ready) check_item(1, 64'(ar));
        if (rstn && w_valid && w_ready) check_item(2, 64'(w));
    end

    task automatic close_test(input string name);
        for (int ch = 0; ch < 3; ch++) begin
            if (exp_q[ch].size() != 0) begin
                $display("%s: %0d expected %s items never arrived", name,
                         exp_q[ch].size(), ch_name[ch]);
                test_errors++;
                exp_q[ch].delete();
            end
        end
        $display("test %-18s %s", name, test_errors == 0 ? "pass" : "FAIL");
        errors += test_errors;
        test_errors = 0;
    endtask

endmodule

`default_nettype wire

// File: dv/udp_axi_cmd_tb.sv
`timescale 1ns/1ns
`default_nettype none

module udp_axi_cmd_tb;

    localparam int N_TESTS   = 7;
    localparam int MAX_W     = 8;
    localparam int DRIVE_DLY = 1;       // after the rising edge
    localparam int QUIET_CYC = 8;       // idle window to catch stray handshakes

    logic                   gmii_rx_clk;
    logic                   rstn;
    logic                   udp_rx_en;
    logic                   udp_rx_done;
    logic [31:0]            udp_rx_data;
    logic                   aw_ready;
    logic                   ar_ready;
    logic                   w_ready;
    logic                   b_valid;
    axi_pkg::axi_aw_t       aw;
    logic                   aw_valid;
    axi_pkg::axi_aw_t       ar;
    logic                   ar_valid;
    axi_pkg::axi_w_t        w;
    logic                   w_valid;
    logic                   b_ready;
    int                     limit_cycles = 0;

    // frame table of name, tag, word count and words
    string       t_name [N_TESTS] = '{"cmd_write", "cmd_read", "cmd_multi", "data_frame",
                                      "ignored_frame", "data_after_ignore", "data_single"};
    logic [7:0]  t_tag  [N_TESTS] = '{8'h00, 8'h00, 8'h00, 8'hff, 8'h55, 8'hff, 8'hff};
    int          t_len  [N_TESTS] = '{2, 2, 7, 5, 4, 3, 2};
    logic [31:0] t_words [N_TESTS][MAX_W] = '{
        '{32'h0061_0300, 32'h4000_1000, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
        '{32'h0050_0f00, 32'h8000_0040, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
        '{32'h00e1_0700, 32'h1234_5678, 32'h0a41_0100, 32'hdead_beef,
          32'h0000_ff00, 32'h0000_0010, 32'h0031_0200, 32'h0},
        '{32'hff00_0000, 32'h0102_0304, 32'ha5a5_5a5a, 32'h0000_0000,
          32'hffff_ffff, 32'h0, 32'h0, 32'h0},
        '{32'h5500_0000, 32'h0001_0000, 32'hff00_0000, 32'h0000_0001,
          32'h0, 32'h0, 32'h0, 32'h0},
        '{32'hff12_3456, 32'hcafe_f00d, 32'h0bad_cafe, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
        '{32'hff00_0000, 32'h1357_9bdf, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0}
    };

    udp_axi_cmd i_dut (.*);

    udp_axi_cmd_checker i_checker (.*);

    initial begin
        gmii_rx_clk = 1'b0;
        forever #50 gmii_rx_clk = ~gmii_rx_clk;
    end

    // random back-pressure and stray responses
    initial begin
        aw_ready = 1'b0;
        ar_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        void'($urandom(32'hf027));
        forever begin
            @(posedge gmii_rx_clk);
            #DRIVE_DLY;
            aw_ready = ($urandom % 4) != 0;
            ar_ready = ($urandom % 4) != 0;
            w_ready  = ($urandom % 4) != 0;
            b_valid  = ($urandom % 8) == 0;
        end
    end

    // header and tag rules give the expected items
    task automatic predict_frame(input int t, input bit push_it, output int n);
        logic [63:0]      h;
        axi_pkg::axi_aw_t d;
        axi_pkg::axi_w_t  b;
        n = 0;
        if (t_tag[t] == 8'h00) begin
            for (int k = 0; k + 1 < t_len[t]; k += 2) begin
                h = {t_words[t][k], t_words[t][k+1]};
                if (h[63:56] == 8'h00) begin
                    d = '{id: h[53:52], addr: h[31:0], len: h[47:40], burst: h[55:54]};
                    n++;
                    if (push_it) i_checker.add_expected(h[48] ? 0 : 1, 64'(d));
                end
            end
        end else if (t_tag[t] == 8'hff) begin
            for (int k = 1; k < t_len[t]; k++) begin  // word 0 is the marker
                b = '{data: t_words[t][k], strb: 4'hf, last: k == t_len[t] - 1};
                n++;
                if (push_it) i_checker.add_expected(2, 64'(b));
            end
        end
    endtask

    task automatic send_frame(input int t);
        for (int k = 0; k < t_len[t]; k++) begin
            @(posedge gmii_rx_clk);
            #DRIVE_DLY;
            udp_rx_en   = 1'b1;
            udp_rx_data = t_words[t][k];
            udp_rx_done = k == t_len[t] - 1;
        end
        @(posedge gmii_rx_clk);
        #DRIVE_DLY;
        udp_rx_en   = 1'b0;
        udp_rx_done = 1'b0;
        udp_rx_data = '0;
    endtask

    task automatic wait_drain(input int budget);
        int cycles;
        cycles = 0;
        while (i_checker.pending() != 0 && cycles < budget * 20) begin
            @(posedge gmii_rx_clk);
            cycles++;
        end
        repeat (QUIET_CYC) @(posedge gmii_rx_clk);
    endtask

    initial begin
        int total_words;
        int total_items;
        int n;
        int errors;
        rstn        = 1'b0;
        udp_rx_en   = 1'b0;
        udp_rx_done = 1'b0;
        udp_rx_data = '0;
        total_words = 0;
        total_items = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            predict_frame(t, 1'b0, n);
            total_words += t_len[t];
            total_items += n;
        end
        limit_cycles = (total_words + total_items) * 20;
        repeat (4) @(posedge gmii_rx_clk);
        #DRIVE_DLY;
        rstn = 1'b1;
        for (int t = 0; t < N_TESTS; t++) begin
            predict_frame(t, 1'b1, n);
            send_frame(t);
            wait_drain(t_len[t] + n);
            i_checker.close_test(t_name[t]);
        end
        errors = i_checker.errors + i_dut.i_chk.fail_count;
        $display("tests %0d, items checked %0d, checker errors %0d, assertion failures %0d",
                 N_TESTS, i_checker.checked, i_checker.errors, i_dut.i_chk.fail_count);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge gmii_rx_clk);
        $display("watchdog expired after %0d cycles, the run did not finish", limit_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: udp_axi_cmd.f
rtl/axi_pkg.sv
rtl/udp_cmd_pkg.sv
rtl/sync_fifo.sv
rtl/udp_frame_parser.sv
rtl/axi_addr_issuer.sv
rtl/axi_wdata_streamer.sv
rtl/udp_axi_cmd.sv
dv/udp_axi_cmd_chk.sv
dv/udp_axi_cmd_checker.sv
dv/udp_axi_cmd_tb.sv

// File: Makefile
TOP       ?= udp_axi_cmd_tb
SEED      ?= 0
LOG       ?= sim.log
FLIST     ?= udp_axi_cmd.f
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+seed+$(SEED) +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, write $(LOG), fail on errors"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "variables: TOP SEED LOG FLIST OBJ_DIR VERILATOR VFLAGS RUN_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	else \
		echo "test passed, see $(LOG)"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
